/* design/fetch_buffer_top.sv */
`timescale 1ns/10ps

module fetch_buffer_top #(
    parameter int NUM_SLOTS    = 4,
    parameter int FIFO_DEPTH   = ibuf_pkg::DEF_FIFO_DEPTH,
    parameter int REFILL_LEVEL = ibuf_pkg::DEF_REFILL_LEVEL
) (
    input  logic                 clock,
    input  logic                 reset_n,
    input  logic                 line_valid,
    input  ibuf_pkg::slot_id_t   line_slot,
    input  isa_pkg::line_t       line_data,
    input  logic [NUM_SLOTS-1:0] flush,
    input  logic [NUM_SLOTS-1:0] fetch_enable,          // Per-slot fetch permission
    input  logic                 issue_ready,
    output logic                 issue_valid,
    output isa_pkg::inst_t       issue_inst,
    output ibuf_pkg::slot_id_t   issue_slot,
    output logic                 fetch_req,
    output ibuf_pkg::slot_id_t   fetch_req_slot
);

    import isa_pkg::*;

    logic [NUM_SLOTS-1:0]  load;
    line_t                 load_line;
    logic [NUM_SLOTS-1:0]  clear;
    logic [NUM_SLOTS-1:0]  empty;
    inst_t [NUM_SLOTS-1:0] head_inst;
    logic [NUM_SLOTS-1:0]  refill;
    logic [NUM_SLOTS-1:0]  pop;

    line_router #(
        .NUM_SLOTS (NUM_SLOTS)
    ) u_router (
        .clock      (clock),
        .reset_n    (reset_n),
        .line_valid (line_valid),
        .line_slot  (line_slot),
        .line_data  (line_data),
        .flush      (flush),
        .load       (load),
        .load_line  (load_line),
        .clear      (clear)
    );

    // One buffer per slot
    for (genvar g = 0; g < NUM_SLOTS; g++) begin : g_slot
        ibuffer #(
            .FIFO_DEPTH   (FIFO_DEPTH),
            .REFILL_LEVEL (REFILL_LEVEL)
        ) u_ibuffer (
            .clock        (clock),
            .reset_n      (reset_n),
            .load         (load[g]),
            .load_line    (load_line),
            .clear        (clear[g]),
            .fetch_enable (fetch_enable[g]),
            .pop          (pop[g]),
            .head_inst    (head_inst[g]),
            .empty        (empty[g]),
            .refill       (refill[g])
        );
    end

    issue_arbiter #(
        .NUM_SLOTS (NUM_SLOTS)
    ) u_arbiter (
        .clock          (clock),
        .reset_n        (reset_n),
        .empty          (empty),
        .head_inst      (head_inst),
        .issue_ready    (issue_ready),
        .refill         (refill),
        .pop            (pop),
        .issue_valid    (issue_valid),
        .issue_inst     (issue_inst),
        .issue_slot     (issue_slot),
        .fetch_req      (fetch_req),
        .fetch_req_slot (fetch_req_slot)
    );

endmodule

/* design/ibuf_pkg.sv */
package ibuf_pkg;

    parameter int MAX_SLOTS = 8;                        // Upper bound on fetch slots
    parameter int SLOT_W    = $clog2(MAX_SLOTS);        // Slot number width
    parameter int COUNT_W   = 5;                        // Occupancy width, depths up to 31

    // Slot number carried with lines, issues and requests
    typedef logic [SLOT_W-1:0] slot_id_t;

    // Buffer occupancy
    typedef logic [COUNT_W-1:0] fifo_count_t;

    parameter int DEF_FIFO_DEPTH   = 24;                // Default words per slot buffer
    parameter int DEF_REFILL_LEVEL = 4;                 // Default refill threshold

endpackage

/* design/ibuffer.sv */
`timescale 1ns/10ps

module ibuffer #(
    parameter int FIFO_DEPTH   = ibuf_pkg::DEF_FIFO_DEPTH,
    parameter int REFILL_LEVEL = ibuf_pkg::DEF_REFILL_LEVEL
) (
    input  logic           clock,
    input  logic           reset_n,
    input  logic           load,                        // New line for this slot
    input  isa_pkg::line_t load_line,                   // Shared line bus from the router
    input  logic           clear,                       // Flush of this slot
    input  logic           fetch_enable,
    input  logic           pop,                         // Issue strobe from the arbiter
    output isa_pkg::inst_t head_inst,
    output logic           empty,
    output logic           refill                       // One-cycle request for another line
);

    import isa_pkg::*;
    import ibuf_pkg::*;

    line_t       line_reg;                              // Line being unpacked
    word_idx_t   word_idx;                              // Next word to push
    logic        write_active;                          // Unpacker busy
    inst_t       wr_word;
    logic        fifo_write;
    logic        fifo_full;
    fifo_count_t fifo_count;
    fifo_count_t count_prev;                            // Occupancy one cycle back
    logic        refill_hit;

    inst_fifo #(
        .DEPTH   (FIFO_DEPTH),
        .COUNT_W ($bits(fifo_count_t))
    ) u_fifo (
        .clock    (clock),
        .reset_n  (reset_n),
        .clear    (clear),
        .write_en (fifo_write),
        .data_in  (wr_word),
        .read_en  (pop),
        .data_out (head_inst),
        .empty    (empty),
        .full     (fifo_full),
        .count    (fifo_count)
    );

    assign wr_word    = line_reg[word_idx * INST_W +: INST_W]; // Word 0 at the bottom
    assign fifo_write = write_active && !fifo_full;     // Full buffer stalls, nothing dropped

    // Line store, payload only
    always_ff @(posedge clock) begin
        if (load) begin
            line_reg <= load_line;
        end
    end

    // Unpacker, one word per non-full cycle
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            word_idx     <= '0;
            write_active <= 1'b0;
        end else if (clear) begin
            word_idx     <= '0;                         // Drop whatever is left of the line
            write_active <= 1'b0;
        end else if (load) begin
            word_idx     <= '0;                         // Newer line replaces the old one
            write_active <= 1'b1;
        end else if (fifo_write) begin
            word_idx <= word_idx + 1'b1;
            if (word_idx == word_idx_t'(LINE_WORDS - 1)) begin
                write_active <= 1'b0;                   // Last word pushed
            end
        end
    end

    // Compare against the delayed count, as the fetch side expects
    assign refill_hit = (count_prev == fifo_count_t'(REFILL_LEVEL)) &&
                        (fifo_count == fifo_count_t'(REFILL_LEVEL - 1));

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            count_prev <= '0;
            refill     <= 1'b0;
        end else begin
            count_prev <= fifo_count;
            refill     <= refill_hit && fetch_enable;   // Lost when fetching is off
        end
    end

endmodule

/* design/inst_fifo.sv */
`timescale 1ns/10ps

module inst_fifo #(
    parameter int DEPTH   = ibuf_pkg::DEF_FIFO_DEPTH,
    parameter int COUNT_W = $bits(ibuf_pkg::fifo_count_t)
) (
    input  logic                  clock,
    input  logic                  reset_n,
    input  logic                  clear,                // Synchronous empty
    input  logic                  write_en,
    input  isa_pkg::inst_t        data_in,
    input  logic                  read_en,
    output isa_pkg::inst_t        data_out,             // Head word, shown ahead of the pop
    output logic                  empty,
    output logic                  full,
    output ibuf_pkg::fifo_count_t count
);

    import isa_pkg::*;

    inst_t              mem [0:DEPTH-1];                // Storage, no reset
    logic [COUNT_W-1:0] rd_ptr;
    logic [COUNT_W-1:0] wr_ptr;
    logic               do_write;
    logic               do_read;

    assign empty    = (count == '0);
    assign full     = (count == COUNT_W'(DEPTH));
    assign do_write = write_en && !full;                // Writes into a full buffer are ignored
    assign do_read  = read_en && !empty;
    assign data_out = mem[rd_ptr];                      // Pop takes the word already on display

    always_ff @(posedge clock) begin
        if (do_write) begin
            mem[wr_ptr] <= data_in;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (clear) begin
            rd_ptr <= '0;                               // Clear wins over a same-cycle write
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                // Wrap by hand, depth need not be a power of two
                wr_ptr <= (wr_ptr == COUNT_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= (rd_ptr == COUNT_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_write && !do_read) begin
                count <= count + 1'b1;
            end else if (do_read && !do_write) begin
                count <= count - 1'b1;
            end                                         // Both or neither keeps the count
        end
    end

endmodule

/* design/isa_pkg.sv */
package isa_pkg;

    parameter int INST_W     = 32;                      // Bits per instruction
    parameter int LINE_WORDS = 16;                      // Instructions per fetch line
    parameter int LINE_W     = INST_W * LINE_WORDS;     // Bits per fetch line
    parameter int WORD_IDX_W = $clog2(LINE_WORDS);      // Index width inside a line

    // Single instruction word
    typedef logic [INST_W-1:0] inst_t;

    // Whole fetch line, word 0 in the lowest bits
    typedef logic [LINE_W-1:0] line_t;

    // Position of a word within a line
    typedef logic [WORD_IDX_W-1:0] word_idx_t;

endpackage

/* design/issue_arbiter.sv */
`timescale 1ns/10ps

module issue_arbiter #(
    parameter int NUM_SLOTS = 4
) (
    input  logic                                  clock,
    input  logic                                  reset_n,
    input  logic [NUM_SLOTS-1:0]                  empty,
    input  isa_pkg::inst_t [NUM_SLOTS-1:0]        head_inst,
    input  logic                                  issue_ready,   // Downstream can take a word
    input  logic [NUM_SLOTS-1:0]                  refill,
    output logic [NUM_SLOTS-1:0]                  pop,
    output logic                                  issue_valid,
    output isa_pkg::inst_t                        issue_inst,
    output ibuf_pkg::slot_id_t                    issue_slot,
    output logic                                  fetch_req,
    output ibuf_pkg::slot_id_t                    fetch_req_slot
);

    import isa_pkg::*;
    import ibuf_pkg::*;

    slot_id_t             last_grant;                   // Slot issued most recently
    slot_id_t             grant_slot;
    inst_t                grant_word;
    logic                 grant_found;
    logic [NUM_SLOTS-1:0] pending;                      // Refills not yet requested
    logic [NUM_SLOTS-1:0] req_release;
    slot_id_t             req_slot;
    logic                 req_found;
    logic                 req_allowed;

    // Round robin search starting just past the last grant
    always_comb begin
        int idx;
        grant_found = 1'b0;
        grant_slot  = last_grant;
        grant_word  = head_inst[0];
        for (int k = 1; k <= NUM_SLOTS; k++) begin
            idx = (int'(last_grant) + k) % NUM_SLOTS;
            if (!grant_found && !empty[idx]) begin
                grant_found = 1'b1;
                grant_slot  = slot_id_t'(idx);
                grant_word  = head_inst[idx];
            end
        end
        for (int s = 0; s < NUM_SLOTS; s++) begin
            pop[s] = issue_ready && grant_found && (grant_slot == slot_id_t'(s));
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            last_grant  <= slot_id_t'(NUM_SLOTS - 1);   // Slot 0 goes first
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= issue_ready && grant_found;
            if (issue_ready && grant_found) begin
                last_grant <= grant_slot;
            end
        end
    end

    // Issued word and its slot
    always_ff @(posedge clock) begin
        issue_inst <= grant_word;
        issue_slot <= grant_slot;
    end

    // Lowest pending slot is released first
    always_comb begin
        req_found   = 1'b0;
        req_slot    = '0;
        req_release = '0;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            if (!req_found && pending[s]) begin
                req_found      = 1'b1;
                req_slot       = slot_id_t'(s);
                req_release[s] = 1'b1;
            end
        end
    end

    assign req_allowed = !fetch_req;                    // Keeps fetch_req a lone pulse

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            pending        <= '0;
            fetch_req      <= 1'b0;
            fetch_req_slot <= '0;
        end else begin
            pending   <= (pending & ~(req_allowed ? req_release : '0)) | refill;
            fetch_req <= req_allowed && req_found;
            if (req_allowed && req_found) begin
                fetch_req_slot <= req_slot;
            end
        end
    end

endmodule

/* design/line_router.sv */
`timescale 1ns/10ps

module line_router #(
    parameter int NUM_SLOTS = 4
) (
    input  logic                 clock,
    input  logic                 reset_n,
    input  logic                 line_valid,            // Line strobe from fetch
    input  ibuf_pkg::slot_id_t   line_slot,
    input  isa_pkg::line_t       line_data,
    input  logic [NUM_SLOTS-1:0] flush,                 // Branch redirect per slot
    output logic [NUM_SLOTS-1:0] load,                  // One-hot load strobe
    output isa_pkg::line_t       load_line,             // Shared by every ibuffer
    output logic [NUM_SLOTS-1:0] clear
);

    import ibuf_pkg::*;

    logic [NUM_SLOTS-1:0] load_next;

    // Slot decode, numbers past the last slot match nothing
    always_comb begin
        for (int s = 0; s < NUM_SLOTS; s++) begin
            load_next[s] = line_valid && (line_slot == slot_id_t'(s)) && !flush[s];
        end
    end

    // Line register, written once for all slots
    always_ff @(posedge clock) begin
        if (line_valid) begin
            load_line <= line_data;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            load  <= '0;
            clear <= '0;
        end else begin
            load  <= load_next;                         // Flushed slot loses its line
            clear <= flush;
        end
    end

endmodule

/* fetch_buffer.f */
design/isa_pkg.sv
design/ibuf_pkg.sv
design/inst_fifo.sv
design/ibuffer.sv
design/line_router.sv
design/issue_arbiter.sv
design/fetch_buffer_top.sv
verification/fetch_buffer_sva.sv
verification/fetch_buffer_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the fetch buffer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module fetch_buffer_tb -f fetch_buffer.f

output=$(./obj_dir/Vfetch_buffer_tb 2>&1 || true)
echo "$output"

if echo "$output" | grep -qx "Simulation PASSED"; then
    exit 0
fi
exit 1

/* verification/fetch_buffer_sva.sv */
`timescale 1ns/10ps

module fetch_buffer_sva #(
    parameter int NUM_SLOTS = 4
) (
    input logic                 clock,
    input logic                 reset_n,
    input logic [NUM_SLOTS-1:0] empty,
    input logic                 issue_ready,
    input logic [NUM_SLOTS-1:0] pop,
    input logic                 fetch_req
);

    // One buffer drained per cycle at most
    pop_onehot: assert property (@(posedge clock) disable iff (!reset_n) $onehot0(pop))
        else $error("pop has more than one slot set");

    pop_not_empty: assert property (@(posedge clock) disable iff (!reset_n)
        (pop & empty) == '0)
        else $error("pop sent to an empty slot");

    // Downstream stall blocks every pop
    pop_needs_ready: assert property (@(posedge clock) disable iff (!reset_n)
        !issue_ready |-> (pop == '0))
        else $error("pop while issue_ready is low");

    fetch_req_pulse: assert property (@(posedge clock) disable iff (!reset_n)
        fetch_req |=> !fetch_req)
        else $error("fetch_req held longer than one cycle");

endmodule

bind issue_arbiter fetch_buffer_sva #(
    .NUM_SLOTS (NUM_SLOTS)
) u_sva (
    .clock       (clock),
    .reset_n     (reset_n),
    .empty       (empty),
    .issue_ready (issue_ready),
    .pop         (pop),
    .fetch_req   (fetch_req)
);

/* verification/fetch_buffer_tb.sv */
`timescale 1ns/10ps

module fetch_buffer_tb;

    import isa_pkg::*;
    import ibuf_pkg::*;

    localparam int NUM_SLOTS    = 4;
    localparam int FIFO_DEPTH   = 24;
    localparam int REFILL_LEVEL = 4;
    localparam int NUM_LINES    = 120;                  // Lines sent over the whole run
    localparam int PERIOD       = 40;                   // Clock period in ns
    localparam int UNPACK_TIME  = 24;                   // Cycles until a sent line sits in its FIFO
    localparam int IDLE_RESTART = 16;                   // Empty cycles before a slot is restarted

    logic                 clock;
    logic                 reset_n;
    logic                 line_valid;
    slot_id_t             line_slot;
    line_t                line_data;
    logic [NUM_SLOTS-1:0] flush;
    logic [NUM_SLOTS-1:0] fetch_enable;
    logic                 issue_ready;
    logic                 issue_valid;
    inst_t                issue_inst;
    slot_id_t             issue_slot;
    logic                 fetch_req;
    slot_id_t             fetch_req_slot;

    inst_t                expected_q [NUM_SLOTS][$];    // Words still due per slot
    int                   unpack_timer [NUM_SLOTS];     // Nonzero while a line is in flight
    int                   idle_cycles [NUM_SLOTS];
    int                   req_q [$];                    // Requests waiting for a line
    int                   lines_sent;
    int                   stall_left;                   // Remaining back-pressure cycles
    logic [NUM_SLOTS-1:0] owed [NUM_SLOTS];             // Slots due before this one again
    logic [NUM_SLOTS-1:0] avail_prev;
    logic                 ready_prev;

    fetch_buffer_top #(
        .NUM_SLOTS    (NUM_SLOTS),
        .FIFO_DEPTH   (FIFO_DEPTH),
        .REFILL_LEVEL (REFILL_LEVEL)
    ) DUT (
        .clock          (clock),
        .reset_n        (reset_n),
        .line_valid     (line_valid),
        .line_slot      (line_slot),
        .line_data      (line_data),
        .flush          (flush),
        .fetch_enable   (fetch_enable),
        .issue_ready    (issue_ready),
        .issue_valid    (issue_valid),
        .issue_inst     (issue_inst),
        .issue_slot     (issue_slot),
        .fetch_req      (fetch_req),
        .fetch_req_slot (fetch_req_slot)
    );

    initial clock = 1'b0;
    always #(PERIOD / 2) clock = ~clock;

    task automatic stop_on_failure();
        $display("Simulation FAILED");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic check_equal(input string what, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            stop_on_failure();
        end
    endtask

    // Random line for one slot, its words queued in order
    task automatic send_line(input int slot);
        line_t line;
        inst_t word;
        for (int w = 0; w < LINE_WORDS; w++) begin
            word = $urandom;
            line[w * INST_W +: INST_W] = word;          // Word 0 at the bottom
            expected_q[slot].push_back(word);
        end
        line_valid         = 1'b1;
        line_slot          = slot_id_t'(slot);
        line_data          = line;
        unpack_timer[slot] = UNPACK_TIME;
        idle_cycles[slot]  = 0;
        lines_sent++;
    endtask

    // Branch redirect, issue held off until the clear has reached the FIFO
    task automatic flush_slot(input int slot);
        issue_ready = 1'b0;
        line_valid  = 1'b0;
        @(posedge clock);
        #2;
        flush[slot] = 1'b1;
        expected_q[slot].delete();                      // Everything buffered is dropped
        @(posedge clock);
        #2;
        flush[slot] = 1'b0;
        @(posedge clock);
        #2;
        stall_left = 0;
    endtask

    function automatic bit all_drained();
        bit done;
        done = (lines_sent >= NUM_LINES);
        for (int s = 0; s < NUM_SLOTS; s++) begin
            if (expected_q[s].size() != 0 || unpack_timer[s] != 0) begin
                done = 1'b0;
            end
        end
        return done;
    endfunction

    // Outputs sampled mid-cycle, away from the drive edge
    always @(negedge clock) begin : monitor
        int                   s;
        inst_t                want;
        logic [NUM_SLOTS-1:0] avail_now;
        if (reset_n) begin
            if (issue_valid) begin
                check_equal("issue_valid after a cycle with issue_ready low", ready_prev, 1);
                s = int'(issue_slot);
                if (s >= NUM_SLOTS || expected_q[s].size() == 0) begin
                    $display("Issue from slot %0d at %0t ns while nothing is due from it",
                             s, $time);
                    stop_on_failure();
                end
                want = expected_q[s].pop_front();
                check_equal($sformatf("issue_inst of slot %0d", s), issue_inst, want);
                check_equal($sformatf("slots still owed before slot %0d", s), owed[s], '0);
                owed[s] = avail_prev & ~(NUM_SLOTS'(1) << s);
                for (int k = 0; k < NUM_SLOTS; k++) begin
                    owed[k][s] = 1'b0;                  // Slot s got its turn
                end
            end
            if (fetch_req) begin
                s = int'(fetch_req_slot);
                check_equal($sformatf("fetch_enable of requested slot %0d", s),
                            fetch_enable[s], 1);
                if (expected_q[s].size() > REFILL_LEVEL) begin
                    $display("Fetch request for slot %0d at %0t ns with %0d words still due",
                             s, $time, expected_q[s].size());
                    stop_on_failure();
                end
                req_q.push_back(s);
            end
            // A slot counts as waiting only with words surely in its FIFO
            avail_now = '0;
            for (int k = 0; k < NUM_SLOTS; k++) begin
                avail_now[k] = (expected_q[k].size() >= 2) && (unpack_timer[k] == 0);
            end
            if (!issue_ready) begin
                avail_now = '0;                         // Fairness only over ready stretches
            end
            for (int k = 0; k < NUM_SLOTS; k++) begin
                owed[k] &= avail_now;
            end
            avail_prev = avail_now;
            ready_prev = issue_ready;
        end
    end

    initial begin : watchdog
        #((NUM_LINES * 40 + 2000) * PERIOD);
        $display("Timeout: the run did not drain all lines in time");
        stop_on_failure();
    end

    initial begin : stimulus
        int slot;
        void'($urandom(45));
        reset_n      = 1'b0;
        line_valid   = 1'b0;
        line_slot    = '0;
        line_data    = '0;
        flush        = '0;
        fetch_enable = 4'b0111;                         // Slot 3 never asks for lines
        issue_ready  = 1'b0;
        lines_sent   = 0;
        stall_left   = 0;
        avail_prev   = '0;
        ready_prev   = 1'b0;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            unpack_timer[s] = 0;
            idle_cycles[s]  = 0;
            owed[s]         = '0;
        end
        repeat (3) @(posedge clock);
        #2;
        reset_n = 1'b1;
        for (int s = 0; s < NUM_SLOTS; s++) begin   // Start-up line for every slot
            @(posedge clock);
            #2;
            issue_ready = 1'b1;
            send_line(s);
        end
        while (!all_drained()) begin
            @(posedge clock);
            #2;
            line_valid = 1'b0;
            for (int s = 0; s < NUM_SLOTS; s++) begin
                if (unpack_timer[s] > 0) begin
                    unpack_timer[s]--;
                end
                if (expected_q[s].size() == 0 && unpack_timer[s] == 0) begin
                    idle_cycles[s]++;
                end else begin
                    idle_cycles[s] = 0;
                end
            end
            if (stall_left > 0) begin
                issue_ready = 1'b0;
                stall_left--;
            end else begin
                issue_ready = 1'b1;
                if ($urandom_range(0, 19) == 0) begin
                    stall_left = $urandom_range(1, 8);  // Back-pressure from the next cycle
                end
            end
            if (lines_sent < NUM_LINES) begin
                if (req_q.size() > 0) begin
                    slot = req_q.pop_front();
                    if (expected_q[slot].size() <= FIFO_DEPTH - LINE_WORDS) begin
                        send_line(slot);
                    end
                end else begin
                    for (int s = 0; s < NUM_SLOTS; s++) begin
                        if (!line_valid && idle_cycles[s] >= IDLE_RESTART) begin
                            send_line(s);               // Starved slot gets a fresh line
                        end
                    end
                end
            end
            if (!line_valid && $urandom_range(0, 149) == 0) begin
                slot = $urandom_range(0, NUM_SLOTS - 1);
                if (unpack_timer[slot] == 0 && expected_q[slot].size() > 0) begin
                    flush_slot(slot);
                end
            end
        end
        issue_ready = 1'b1;
        repeat (30) @(posedge clock);                   // Quiet tail, stray issues still fail
        $display("Simulation PASSED");
        $finish;
    end

endmodule
